/* design/cdb_config.svh */
// Result broadcast configuration

`ifndef CDB_CONFIG_SVH
`define CDB_CONFIG_SVH

// Physical register file
`define PRF_SIZE 64  // Gives a 6-bit tag

// Result payload width
`define XLEN 64

// ----------------------------------------
// Broadcast fabric sizing
// ----------------------------------------

// Reporting units: mem1, mem2, mult1, mult2, add1, add2
`define NUM_FU 6

// Common data bus lanes per cycle
`define NUM_CDB 2

`endif

/* design/cdb_pkg.sv */
// Result broadcast types

`default_nettype none

package cdb_pkg;

	`include "cdb_config.svh"

	// Physical register index
	typedef logic [$clog2(`PRF_SIZE)-1:0] prf_tag_t;

	// ----------------------------------------
	// Unit positions, highest priority on top
	// ----------------------------------------
	typedef enum logic [2:0] {
		FU_ADD2  = 3'd0,  // Lowest priority
		FU_ADD1  = 3'd1,
		FU_MULT2 = 3'd2,
		FU_MULT1 = 3'd3,
		FU_MEM2  = 3'd4,
		FU_MEM1  = 3'd5   // Highest priority
	} fu_id_e;

	// One bit per unit, indexed by fu_id_e
	typedef logic [`NUM_FU-1:0] fu_mask_t;

	// What a unit presents when it has a finished result
	typedef struct packed {
		logic              ready;
		prf_tag_t          tag;
		logic [`XLEN-1:0]  value;
	} fu_result_t;

	// What one bus lane broadcasts
	typedef struct packed {
		logic              valid;
		prf_tag_t          tag;
		logic [`XLEN-1:0]  value;
	} cdb_bus_t;

endpackage

`default_nettype wire

/* design/cdb_grant_chain.sv */
// Fixed-priority lane grants

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module cdb_grant_chain (
	input  cdb_pkg::fu_mask_t fu_ready,
	output cdb_pkg::fu_mask_t lane_grant [`NUM_CDB],
	output cdb_pkg::fu_mask_t send_in_fail
);

	import cdb_pkg::*;

	fu_mask_t lane_req [`NUM_CDB];  // Requests still open at each lane
	fu_mask_t granted;              // Union of all lane grants

	// ----------------------------------------
	// Highest set bit of a request vector
	// ----------------------------------------
	function automatic fu_mask_t pick_highest(input fu_mask_t req);
		fu_mask_t gnt;
		gnt = '0;
		// Scan upward so the highest ready unit overwrites the rest
		for (int i = FU_ADD2; i <= FU_MEM1; i++) begin
			if (req[i]) begin
				gnt    = '0;
				gnt[i] = 1'b1;
			end
		end
		return gnt;
	endfunction

	// ----------------------------------------
	// Cascade across the lanes
	// ----------------------------------------
	always_comb begin
		lane_req[0] = fu_ready;  // Lane 0 sees every ready unit
		for (int l = 1; l < `NUM_CDB; l++) begin
			// Later lanes only see what earlier ones left over
			lane_req[l] = lane_req[l-1] & ~lane_grant[l-1];
		end
	end

	always_comb begin
		for (int l = 0; l < `NUM_CDB; l++) begin
			lane_grant[l] = pick_highest(lane_req[l]);
		end
	end

	always_comb begin
		granted = '0;
		for (int l = 0; l < `NUM_CDB; l++) begin
			granted = granted | lane_grant[l];
		end
	end

	// A ready unit that found no lane must present its result again
	assign send_in_fail = fu_ready & ~granted;

endmodule

`default_nettype wire

/* design/cdb_lane.sv */
// Single common data bus lane

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module cdb_lane (
	input  logic                clock,
	input  logic                arst_n,
	input  cdb_pkg::fu_mask_t   grant,
	input  cdb_pkg::fu_result_t fu_results [`NUM_FU],
	output cdb_pkg::cdb_bus_t   cdb
);

	import cdb_pkg::*;

	prf_tag_t         sel_tag;    // Tag of the granted unit
	logic [`XLEN-1:0] sel_value;  // Value of the granted unit
	logic             sel_any;

	// ----------------------------------------
	// One-hot result mux
	// ----------------------------------------
	always_comb begin
		sel_tag   = '0;
		sel_value = '0;
		for (int i = 0; i < `NUM_FU; i++) begin
			if (grant[i]) begin
				sel_tag   = sel_tag | fu_results[i].tag;
				sel_value = sel_value | fu_results[i].value;
			end
		end
	end

	assign sel_any = |grant;  // Grant is one-hot or zero

	// ----------------------------------------
	// Broadcast register
	// ----------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cdb.valid <= 1'b0;
			cdb.tag   <= '0;
			cdb.value <= '0;
		end else begin
			cdb.valid <= sel_any;
			if (sel_any) begin  // Payload holds when idle
				cdb.tag   <= sel_tag;
				cdb.value <= sel_value;
			end
		end
	end

endmodule

`default_nettype wire

/* design/prf_writeback.sv */
// Physical register file with bus write ports

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module prf_writeback (
	input  logic              clock,
	input  logic              arst_n,
	input  cdb_pkg::cdb_bus_t cdb [`NUM_CDB],
	input  logic              alloc_valid,
	input  cdb_pkg::prf_tag_t alloc_tag,
	input  cdb_pkg::prf_tag_t rd_tag,
	output logic [`XLEN-1:0]  rd_value,
	output logic              rd_ready
);

	logic [`XLEN-1:0]    prf_value [`PRF_SIZE];  // Register contents
	logic [`PRF_SIZE-1:0] prf_ready;              // Result present per register

	logic [`PRF_SIZE-1:0] wr_hit;     // Registers written by some lane this edge
	logic [`PRF_SIZE-1:0] alloc_clr;  // Register being reallocated

	// ----------------------------------------
	// Write and clear decode
	// ----------------------------------------
	always_comb begin
		wr_hit = '0;
		for (int l = 0; l < `NUM_CDB; l++) begin
			if (cdb[l].valid) begin
				wr_hit[cdb[l].tag] = 1'b1;
			end
		end
	end

	always_comb begin
		alloc_clr = '0;
		if (alloc_valid) begin
			alloc_clr[alloc_tag] = 1'b1;
		end
	end

	// ----------------------------------------
	// Ready bits
	// ----------------------------------------
	// A bus write on the same edge beats the allocate clear
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			prf_ready <= '0;
		end else begin
			prf_ready <= (prf_ready & ~alloc_clr) | wr_hit;
		end
	end

	// ----------------------------------------
	// Register values
	// ----------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `PRF_SIZE; r++) begin
				prf_value[r] <= '0;
			end
		end else begin
			// Lanes never carry the same tag, so the order is free
			for (int l = 0; l < `NUM_CDB; l++) begin
				if (cdb[l].valid) begin
					prf_value[cdb[l].tag] <= cdb[l].value;
				end
			end
		end
	end

	// Allocate leaves the old value in place

	// Combinational read port
	assign rd_value = prf_value[rd_tag];
	assign rd_ready = prf_ready[rd_tag];

endmodule

`default_nettype wire

/* design/cdb_top.sv */
// Result broadcast stage top level

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module cdb_top (
	input  logic                clock,
	input  logic                arst_n,
	input  cdb_pkg::fu_result_t fu_results [`NUM_FU],  // Indexed by fu_id_e
	input  logic                alloc_valid,           // Rename allocate strobe
	input  cdb_pkg::prf_tag_t   alloc_tag,
	input  cdb_pkg::prf_tag_t   rd_tag,
	output cdb_pkg::fu_mask_t   send_in_fail,
	output cdb_pkg::cdb_bus_t   cdb [`NUM_CDB],
	output logic [`XLEN-1:0]    rd_value,
	output logic                rd_ready
);

	import cdb_pkg::*;

	fu_mask_t fu_ready;                 // Ready levels gathered from the units
	fu_mask_t lane_grant [`NUM_CDB];    // One-hot or zero per lane

	// Ready bits out of the result structs
	always_comb begin
		for (int i = 0; i < `NUM_FU; i++) begin
			fu_ready[i] = fu_results[i].ready;
		end
	end

	// ----------------------------------------
	// Arbitration
	// ----------------------------------------
	cdb_grant_chain u_cdb_grant_chain (
		.fu_ready     (fu_ready),
		.lane_grant   (lane_grant),
		.send_in_fail (send_in_fail)
	);

	// ----------------------------------------
	// Bus lanes
	// ----------------------------------------
	for (genvar l = 0; l < `NUM_CDB; l++) begin : g_lane
		cdb_lane u_cdb_lane (
			.clock      (clock),
			.arst_n     (arst_n),
			.grant      (lane_grant[l]),
			.fu_results (fu_results),
			.cdb        (cdb[l])
		);
	end

	// ----------------------------------------
	// Register file drains both lanes
	// ----------------------------------------
	prf_writeback u_prf_writeback (
		.clock       (clock),
		.arst_n      (arst_n),
		.cdb         (cdb),
		.alloc_valid (alloc_valid),
		.alloc_tag   (alloc_tag),
		.rd_tag      (rd_tag),
		.rd_value    (rd_value),
		.rd_ready    (rd_ready)
	);

endmodule

`default_nettype wire

/* verif/cdb_checker.sv */
// Bus lane assertions

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module cdb_checker (
	input logic              clock,
	input logic              arst_n,
	input cdb_pkg::fu_mask_t lane_grant [`NUM_CDB],
	input cdb_pkg::fu_mask_t send_in_fail,
	input cdb_pkg::cdb_bus_t cdb [`NUM_CDB]
);

	// Two lanes with one tag would write one register on the same edge
	a_distinct_tags: assert property (@(posedge clock) disable iff (!arst_n)
		(cdb[0].valid && cdb[1].valid) |-> (cdb[0].tag != cdb[1].tag))
		else $error("Both bus lanes carry tag %0d", cdb[0].tag);

	// A unit fails only behind two grants to higher-priority units
	a_grant_or_fail: assert property (@(posedge clock) disable iff (!arst_n)
		(send_in_fail != '0) |->
			(lane_grant[1] != '0 && send_in_fail < lane_grant[1] &&
			lane_grant[1] < lane_grant[0]))
		else $error("A failed unit is not below both lane grants in priority");

	// ----------------------------------------
	// Per-lane checks
	// ----------------------------------------
	for (genvar l = 0; l < `NUM_CDB; l++) begin : g_lane
		a_grant_onehot: assert property (@(posedge clock) disable iff (!arst_n)
			$onehot0(lane_grant[l]))
			else $error("Lane %0d grant is not one-hot", l);

		// First edge out of reset still samples the reset value
		a_idle_after_reset: assert property (@(posedge clock)
			$rose(arst_n) |-> !cdb[l].valid)
			else $error("Lane %0d is valid right after reset", l);
	end

endmodule

bind cdb_top cdb_checker u_cdb_checker (
	.clock        (clock),
	.arst_n       (arst_n),
	.lane_grant   (lane_grant),
	.send_in_fail (send_in_fail),
	.cdb          (cdb)
);

`default_nettype wire

/* verif/cdb_tb.sv */
// Result broadcast stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "cdb_config.svh"

module cdb_tb;

	import cdb_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int FIELDS     = 25;  // Words per line of the tests file
	localparam int MAX_LINES  = 64;
	localparam logic [63:0] EMPTY = '1;

	logic             clock;
	logic             arst_n;
	fu_result_t       fu_results [`NUM_FU];
	logic             alloc_valid;
	prf_tag_t         alloc_tag;
	prf_tag_t         rd_tag;
	fu_mask_t         send_in_fail;
	cdb_bus_t         cdb [`NUM_CDB];
	logic [`XLEN-1:0] rd_value;
	logic             rd_ready;

	logic [63:0] vec [FIELDS*MAX_LINES];
	cdb_bus_t    exp_bus [`NUM_CDB];  // Broadcast due from the previous line
	int          num_lines;
	logic        loaded;
	int          mask_errors;
	int          bus_errors;
	int          read_errors;

	cdb_top u_cdb_top (
		.clock (clock), .arst_n (arst_n), .fu_results (fu_results),
		.alloc_valid (alloc_valid), .alloc_tag (alloc_tag), .rd_tag (rd_tag),
		.send_in_fail (send_in_fail), .cdb (cdb),
		.rd_value (rd_value), .rd_ready (rd_ready)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_mask(input string name, input fu_mask_t exp, input fu_mask_t act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
			mask_errors++;
		end
	endtask

	task automatic check_bus(input string name, input cdb_bus_t exp, input cdb_bus_t act);
		// An idle lane keeps its old payload
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			$display("Fail at %0t: %s expected valid %b tag %h value %h, got valid %b tag %h value %h",
				$time, name, exp.valid, exp.tag, exp.value, act.valid, act.tag, act.value);
			bus_errors++;
		end
	endtask

	task automatic check_read(input logic exp_ready, input logic [`XLEN-1:0] exp_value);
		if (rd_ready !== exp_ready) begin
			$display("Fail at %0t: rd_ready expected %b, got %b", $time, exp_ready, rd_ready);
			read_errors++;
		end
		if (rd_value !== exp_value) begin
			$display("Fail at %0t: rd_value expected %h, got %h", $time, exp_value, rd_value);
			read_errors++;
		end
	endtask

	// ----------------------------------------
	// Vector access
	// ----------------------------------------
	task automatic drive_line(input int n);
		int base;
		base = n * FIELDS;
		for (int i = 0; i < `NUM_FU; i++) begin
			fu_results[i].ready = vec[base][i];
			fu_results[i].tag   = prf_tag_t'(vec[base + 1 + int'(FU_MEM1) - i]);  // mem1 first
			fu_results[i].value = vec[base + 7 + int'(FU_MEM1) - i];
		end
		alloc_valid = vec[base + 13][0];
		alloc_tag   = prf_tag_t'(vec[base + 14]);
		rd_tag      = prf_tag_t'(vec[base + 15]);
	endtask

	function automatic cdb_bus_t bus_from(input int at);
		cdb_bus_t b;
		b.valid = vec[at][0];
		b.tag   = prf_tag_t'(vec[at + 1]);
		b.value = vec[at + 2];
		return b;
	endfunction

	initial begin
		loaded      = 1'b0;
		mask_errors = 0;
		bus_errors  = 0;
		read_errors = 0;
		arst_n      = 1'b0;
		alloc_valid = 1'b0;
		alloc_tag   = '0;
		rd_tag      = '0;
		for (int i = 0; i < `NUM_FU; i++) begin
			fu_results[i] = '0;
		end
		for (int l = 0; l < `NUM_CDB; l++) begin
			exp_bus[l] = '0;  // Lanes leave reset idle
		end
		for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
			vec[i] = EMPTY;
		end
		$readmemh("verif/cdb_tests.txt", vec);
		num_lines = 0;
		while (num_lines < MAX_LINES && vec[num_lines * FIELDS] != EMPTY) begin
			num_lines++;
		end
		loaded = 1'b1;
		if (num_lines == 0) begin
			$display("No test vectors were found in verif/cdb_tests.txt");
			read_errors++;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		// One extra pass checks the broadcast of the last line
		for (int n = 0; n <= num_lines; n++) begin
			if (n < num_lines) begin
				drive_line(n);
			end
			#(CLK_PERIOD / 4);
			for (int l = 0; l < `NUM_CDB; l++) begin
				check_bus($sformatf("cdb[%0d]", l), exp_bus[l], cdb[l]);
			end
			if (n < num_lines) begin
				check_mask("send_in_fail", fu_mask_t'(vec[n * FIELDS + 16]), send_in_fail);
				check_read(vec[n * FIELDS + 23][0], vec[n * FIELDS + 24]);
				for (int l = 0; l < `NUM_CDB; l++) begin
					exp_bus[l] = bus_from(n * FIELDS + 17 + 3 * l);
				end
			end
			@(negedge clock);
		end
		$display("Errors: send_in_fail %0d, cdb %0d, read port %0d",
			mask_errors, bus_errors, read_errors);
		if (mask_errors + bus_errors + read_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (loaded === 1'b1);
		#((num_lines + 10) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", num_lines + 10);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/cdb_tests.txt */
// rdy | tags mem1..add2 | values mem1..add2 | alloc valid,tag | rd_tag | exp send_in_fail |
// exp lane0 valid,tag,value | exp lane1 valid,tag,value (next cycle) | exp rd_ready,rd_value
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 05  00  0 00 0  0 00 0  0 0
01  00 00 00 00 00 0a  0 0 0 0 0 1234  0 00 3f  00  1 0a 1234  0 00 0  0 0
20  0b 00 00 00 00 00  fedcba9876543210 0 0 0 0 0  0 00 0a  00  1 0b fedcba9876543210  0 00 0  0 0
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 0a  00  0 00 0  0 00 0  1 1234
3f  11 12 13 14 15 16  a1 a2 a3 a4 a5 a6  0 00 0b  0f  1 11 a1  1 12 a2  1 fedcba9876543210
0f  00 00 13 14 15 16  0 0 a3 a4 a5 a6  0 00 11  03  1 13 a3  1 14 a4  0 0
03  00 00 00 00 15 16  0 0 0 0 a5 a6  0 00 11  00  1 15 a5  1 16 a6  1 a1
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 12  00  0 00 0  0 00 0  1 a2
14  00 21 00 22 00 00  0 b2 0 b4 0 0  0 00 13  00  1 21 b2  1 22 b4  1 a3
0a  00 00 23 00 24 00  0 0 b3 0 b5 0  0 00 14  00  1 23 b3  1 24 b5  1 a4
21  25 00 00 00 00 26  c1 0 0 0 0 c6  0 00 21  00  1 25 c1  1 26 c6  1 b2
06  00 00 00 27 28 00  0 0 0 c4 c5 0  0 00 24  00  1 27 c4  1 28 c5  1 b5
19  00 29 2a 00 00 2b  0 d2 d3 0 0 d6  0 00 26  01  1 29 d2  1 2a d3  1 c6
01  00 00 00 00 00 2b  0 0 0 0 0 d6  1 0a 0a  00  1 2b d6  0 00 0  1 1234
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 0a  00  0 00 0  0 00 0  0 1234
20  30 00 00 00 00 00  e1 0 0 0 0 0  0 00 2b  00  1 30 e1  0 00 0  1 d6
00  00 00 00 00 00 00  0 0 0 0 0 0  1 30 30  00  0 00 0  0 00 0  0 0
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 30  00  0 00 0  0 00 0  1 e1
00  00 00 00 00 00 00  0 0 0 0 0 0  0 00 3e  00  0 00 0  0 00 0  0 0

/* vlog.f */
+incdir+design
design/cdb_pkg.sv
design/cdb_grant_chain.sv
design/cdb_lane.sv
design/prf_writeback.sv
design/cdb_top.sv
verif/cdb_checker.sv
verif/cdb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the result broadcast testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cdb_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcdb_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
